// File: Bender.yml
package:
  name: cluster_boot

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cluster_map_pkg.sv
      - design/cluster_desc_pkg.sv
      - design/boot_sequencer.sv
      - design/core_write_decoder.sv
      - design/core_slot_ctrl.sv
      - design/desc_collector.sv
      - design/cluster_boot_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/cluster_boot_tb.sv

// File: design/boot_sequencer.sv
`default_nettype none

`include "cluster_macros.svh"

module boot_sequencer (
  input  wire                              clk,
  input  wire                              rst,
  output cluster_map_pkg::axi_addr_t       awaddr,
  output logic                             awvalid,
  input  wire                              awready,
  output cluster_map_pkg::axi_data_t       wdata,
  output cluster_map_pkg::axi_strb_t       wstrb,
  output logic                             wlast,
  output logic                             wvalid,
  input  wire                              wready,
  input  wire cluster_map_pkg::axi_resp_t  bresp,
  input  wire                              bvalid,
  output logic                             slot_wr,
  output cluster_desc_pkg::slot_idx_t      slot_wr_idx,
  output cluster_desc_pkg::slot_addr_t     slot_wr_addr,
  output logic                             desc_valid,
  output cluster_map_pkg::core_idx_t       desc_core,
  output cluster_desc_pkg::slot_idx_t      desc_slot,
  input  wire [`CLUSTER_NUM_CORES-1:0]     desc_ready,
  output logic                             tx_enable,
  output logic                             rx_enable
);

  localparam int unsigned DELAY_W = $clog2(`CLUSTER_BOOT_DELAY + 1);
  localparam cluster_map_pkg::axi_strb_t HOLD_STRB = 8'h80;  // lane of the hold byte
  localparam cluster_map_pkg::core_idx_t LAST_CORE =
    cluster_map_pkg::core_idx_t'(`CLUSTER_NUM_CORES - 1);

  cluster_desc_pkg::seq_state_t state;
  logic [DELAY_W-1:0]           delay_cnt;
  cluster_map_pkg::core_idx_t   core_sel;   // core being released
  logic                         desc_fire;

  // release write is always data zero into the hold byte
  assign wdata = '0;
  assign wstrb = HOLD_STRB;
  assign wlast = 1'b1;     // single beat

  assign desc_fire = desc_valid && desc_ready[desc_core];

  // ************************************************************************
  // boot FSM
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= cluster_desc_pkg::idle_wait;
      delay_cnt   <= '0;
      core_sel    <= '0;
      awvalid     <= 1'b0;
      wvalid      <= 1'b0;
      slot_wr     <= 1'b0;
      slot_wr_idx <= '0;
      desc_valid  <= 1'b0;
      desc_core   <= '0;
      desc_slot   <= '0;
      tx_enable   <= 1'b0;
      rx_enable   <= 1'b0;
    end else begin
      case (state)
        cluster_desc_pkg::idle_wait: begin
          delay_cnt <= delay_cnt + 1'b1;
          if (delay_cnt == DELAY_W'(`CLUSTER_BOOT_DELAY - 1)) begin
            state <= cluster_desc_pkg::release_core;
          end
        end

        cluster_desc_pkg::release_core: begin
          awaddr  <= {core_sel, `CLUSTER_CTRL_OFFSET};
          awvalid <= 1'b1;
          wvalid  <= 1'b1;
          state   <= cluster_desc_pkg::await_resp;
        end

        cluster_desc_pkg::await_resp: begin
          // each channel drops on its own handshake
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if (bvalid) begin
            if (bresp != 2'b00) begin
              state <= cluster_desc_pkg::release_core;  // same core again
            end else if (core_sel == LAST_CORE) begin
              tx_enable    <= 1'b1;
              rx_enable    <= 1'b1;
              slot_wr      <= 1'b1;
              slot_wr_idx  <= '0;
              slot_wr_addr <= `CLUSTER_SLOT_BASE;
              state        <= cluster_desc_pkg::program_slots;
            end else begin
              core_sel <= core_sel + 1'b1;
              state    <= cluster_desc_pkg::release_core;
            end
          end
        end

        cluster_desc_pkg::program_slots: begin
          if (slot_wr_idx == '1) begin
            slot_wr    <= 1'b0;
            desc_valid <= 1'b1;
            desc_core  <= '0;
            desc_slot  <= '0;
            state      <= cluster_desc_pkg::sweep_desc;
          end else begin
            slot_wr_idx  <= slot_wr_idx + 1'b1;
            slot_wr_addr <= slot_wr_addr + 7'(`CLUSTER_SLOT_STEP);
          end
        end

        cluster_desc_pkg::sweep_desc: begin
          // core index steps fastest, then slot
          if (desc_fire) begin
            desc_core <= desc_core + 1'b1;
            if (desc_core == LAST_CORE) begin
              desc_slot <= desc_slot + 1'b1;
              if (desc_slot == '1) begin
                desc_valid <= 1'b0;
                state      <= cluster_desc_pkg::running;
              end
            end
          end
        end

        cluster_desc_pkg::running: ;  // boot done, enables stay up

        default: state <= cluster_desc_pkg::idle_wait;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/cluster_boot_top.sv
`default_nettype none

`include "cluster_macros.svh"

module cluster_boot_top (
  input  wire                                clk,
  input  wire                                rst,
  output wire                                tx_enable,
  output wire                                rx_enable,
  output wire [`CLUSTER_NUM_CORES-1:0]       cores_released,
  output wire                                out_valid,
  output wire cluster_map_pkg::core_idx_t    out_core,
  output wire cluster_desc_pkg::slot_idx_t   out_slot,
  output wire cluster_desc_pkg::slot_addr_t  out_addr
);

  // sequencer to decoder
  wire cluster_map_pkg::axi_addr_t   awaddr;
  wire                               awvalid;
  wire                               awready;
  wire cluster_map_pkg::axi_data_t   wdata;
  wire cluster_map_pkg::axi_strb_t   wstrb;
  wire                               wlast;
  wire                               wvalid;
  wire                               wready;
  wire cluster_map_pkg::axi_resp_t   bresp;
  wire                               bvalid;

  // decoder to cores
  wire [`CLUSTER_NUM_CORES-1:0]      ctrl_wr;
  wire cluster_map_pkg::axi_data_t   ctrl_data;
  wire cluster_map_pkg::axi_strb_t   ctrl_strb;

  // broadcast from the sequencer
  wire                               slot_wr;
  wire cluster_desc_pkg::slot_idx_t  slot_wr_idx;
  wire cluster_desc_pkg::slot_addr_t slot_wr_addr;
  wire                               desc_valid;
  wire cluster_map_pkg::core_idx_t   desc_core;
  wire cluster_desc_pkg::slot_idx_t  desc_slot;
  wire [`CLUSTER_NUM_CORES-1:0]      desc_ready;

  // core queues to collector
  wire [`CLUSTER_NUM_CORES-1:0]      q_valid;
  wire [`CLUSTER_NUM_CORES-1:0]      q_pop;
  wire cluster_desc_pkg::slot_idx_t  q_slot [`CLUSTER_NUM_CORES];
  wire cluster_desc_pkg::slot_addr_t q_addr [`CLUSTER_NUM_CORES];

  boot_sequencer u_seq (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid),
    .slot_wr(slot_wr), .slot_wr_idx(slot_wr_idx), .slot_wr_addr(slot_wr_addr),
    .desc_valid(desc_valid), .desc_core(desc_core), .desc_slot(desc_slot),
    .desc_ready(desc_ready),
    .tx_enable(tx_enable), .rx_enable(rx_enable)
  );

  core_write_decoder u_dec (
    .clk(clk), .rst(rst),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid),
    .ctrl_wr(ctrl_wr), .ctrl_data(ctrl_data), .ctrl_strb(ctrl_strb)
  );

  for (genvar c = 0; c < `CLUSTER_NUM_CORES; c++) begin : g_core
    core_slot_ctrl #(.CORE_ID(c)) u_core (
      .clk(clk), .rst(rst),
      .ctrl_wr(ctrl_wr[c]), .ctrl_data(ctrl_data), .ctrl_strb(ctrl_strb),
      .slot_wr(slot_wr), .slot_wr_idx(slot_wr_idx), .slot_wr_addr(slot_wr_addr),
      .desc_valid(desc_valid), .desc_core(desc_core), .desc_slot(desc_slot),
      .desc_ready(desc_ready[c]),
      .q_valid(q_valid[c]), .q_slot(q_slot[c]), .q_addr(q_addr[c]), .q_pop(q_pop[c]),
      .released(cores_released[c])
    );
  end

  desc_collector u_coll (
    .clk(clk), .rst(rst),
    .q_valid(q_valid), .q_slot(q_slot), .q_addr(q_addr), .q_pop(q_pop),
    .out_valid(out_valid), .out_core(out_core), .out_slot(out_slot), .out_addr(out_addr)
  );

endmodule

`default_nettype wire

// File: design/cluster_desc_pkg.sv
`default_nettype none

`include "cluster_macros.svh"

// ************************************************************************
// receive descriptor fields and control state
// ************************************************************************

package cluster_desc_pkg;

  typedef logic [`CLUSTER_SLOT_BITS-1:0] slot_idx_t;
  typedef logic [6:0] slot_addr_t;  // slot base address

  // round-robin pointer of the collector
  typedef logic [`CLUSTER_CORE_BITS-1:0] rr_ptr_t;

  // boot phases
  typedef enum logic [2:0] {
    idle_wait,      // counting the boot delay
    release_core,   // issue the control write to the current core
    await_resp,     // wait for the write response
    program_slots,  // broadcast the slot table
    sweep_desc,     // one descriptor per (core, slot)
    running
  } seq_state_t;

endpackage

`default_nettype wire

// File: design/cluster_macros.svh
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// cluster geometry
`define CLUSTER_NUM_CORES   8
`define CLUSTER_CORE_BITS   3

// receive slots per core
`define CLUSTER_SLOTS       16
`define CLUSTER_SLOT_BITS   4

// cycles from reset release to the first release write
`define CLUSTER_BOOT_DELAY  1000

// per-core control word, hold flag in byte lane 7
`define CLUSTER_CTRL_OFFSET 16'hFFF8

// slot table contents, slot n sits at base + n*step
`define CLUSTER_SLOT_BASE   7'h40
`define CLUSTER_SLOT_STEP   4

// descriptor queue inside each core
`define CLUSTER_QUEUE_DEPTH 4

`endif

// File: design/cluster_map_pkg.sv
`default_nettype none

`include "cluster_macros.svh"

// ************************************************************************
// address map of the cluster and the AXI write fields
// ************************************************************************

package cluster_map_pkg;

  // core index, selects one core of the cluster
  typedef logic [`CLUSTER_CORE_BITS-1:0] core_idx_t;

  // {core index, 16-bit offset inside the core}
  typedef logic [`CLUSTER_CORE_BITS+16-1:0] axi_addr_t;

  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  axi_strb_t;   // one bit per byte lane
  typedef logic [1:0]  axi_resp_t;   // OKAY / SLVERR on the b channel

endpackage

`default_nettype wire

// File: design/core_slot_ctrl.sv
`default_nettype none

`include "cluster_macros.svh"

module core_slot_ctrl #(
  parameter int unsigned CORE_ID = 0
) (
  input  wire                                clk,
  input  wire                                rst,
  input  wire                                ctrl_wr,
  input  wire cluster_map_pkg::axi_data_t    ctrl_data,
  input  wire cluster_map_pkg::axi_strb_t    ctrl_strb,
  input  wire                                slot_wr,
  input  wire cluster_desc_pkg::slot_idx_t   slot_wr_idx,
  input  wire cluster_desc_pkg::slot_addr_t  slot_wr_addr,
  input  wire                                desc_valid,
  input  wire cluster_map_pkg::core_idx_t    desc_core,
  input  wire cluster_desc_pkg::slot_idx_t   desc_slot,
  output logic                               desc_ready,
  output logic                               q_valid,
  output cluster_desc_pkg::slot_idx_t        q_slot,
  output cluster_desc_pkg::slot_addr_t       q_addr,
  input  wire                                q_pop,
  output logic                               released
);

  localparam int unsigned DEPTH    = `CLUSTER_QUEUE_DEPTH;
  localparam int unsigned PTR_W    = $clog2(DEPTH);
  localparam int unsigned CNT_W    = $clog2(DEPTH + 1);
  localparam int unsigned HOLD_BIT = 56;

  logic                         held;
  cluster_desc_pkg::slot_addr_t slot_tab [`CLUSTER_SLOTS];
  logic                         acc;
  logic                         acc_r;      // lookup stage in front of the queue
  cluster_desc_pkg::slot_idx_t  acc_slot;
  cluster_desc_pkg::slot_addr_t acc_addr;
  cluster_desc_pkg::slot_idx_t  q_slot_mem [DEPTH];
  cluster_desc_pkg::slot_addr_t q_addr_mem [DEPTH];
  logic [PTR_W-1:0]             wr_ptr;
  logic [PTR_W-1:0]             rd_ptr;
  logic [CNT_W-1:0]             count;
  logic                         full;

  assign released   = !held;
  assign full       = (count + CNT_W'(acc_r)) >= CNT_W'(DEPTH);  // counts the lookup stage
  assign desc_ready = released && !full;
  assign acc = desc_valid && desc_ready && (desc_core == cluster_map_pkg::core_idx_t'(CORE_ID));

  always_ff @(posedge clk) begin
    if (rst) begin
      held  <= 1'b1;
      acc_r <= 1'b0;
    end else begin
      if (ctrl_wr && ctrl_strb[HOLD_BIT/8]) held <= ctrl_data[HOLD_BIT];
      acc_r <= acc;
    end
  end

  // slot table and lookup
  always_ff @(posedge clk) begin
    if (slot_wr) slot_tab[slot_wr_idx] <= slot_wr_addr;
    if (acc) begin
      acc_slot <= desc_slot;
      acc_addr <= slot_tab[desc_slot];
    end
    if (acc_r) begin
      q_slot_mem[wr_ptr] <= acc_slot;
      q_addr_mem[wr_ptr] <= acc_addr;
    end
  end

  // ************************************************************************
  // output queue
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (acc_r) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (q_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(acc_r) - CNT_W'(q_pop);
    end
  end

  assign q_valid = (count != '0);
  assign q_slot  = q_slot_mem[rd_ptr];
  assign q_addr  = q_addr_mem[rd_ptr];

endmodule

`default_nettype wire

// File: design/core_write_decoder.sv
`default_nettype none

`include "cluster_macros.svh"

module core_write_decoder (
  input  wire                              clk,
  input  wire                              rst,
  input  wire cluster_map_pkg::axi_addr_t  awaddr,
  input  wire                              awvalid,
  output logic                             awready,
  input  wire cluster_map_pkg::axi_data_t  wdata,
  input  wire cluster_map_pkg::axi_strb_t  wstrb,
  input  wire                              wlast,
  input  wire                              wvalid,
  output logic                             wready,
  output cluster_map_pkg::axi_resp_t       bresp,
  output logic                             bvalid,
  output logic [`CLUSTER_NUM_CORES-1:0]    ctrl_wr,
  output cluster_map_pkg::axi_data_t       ctrl_data,
  output cluster_map_pkg::axi_strb_t       ctrl_strb
);

  localparam cluster_map_pkg::axi_resp_t RESP_OKAY   = 2'b00;
  localparam cluster_map_pkg::axi_resp_t RESP_SLVERR = 2'b10;

  cluster_map_pkg::core_idx_t core_idx;
  logic [15:0]                offset;
  logic                       accept;
  logic                       wr_ok;

  assign core_idx = awaddr[$bits(cluster_map_pkg::axi_addr_t)-1 -: `CLUSTER_CORE_BITS];
  assign offset   = awaddr[15:0];

  // address and data are taken together, one write in flight
  assign accept  = awvalid && wvalid && !bvalid;
  assign awready = accept;
  assign wready  = accept;

  // only single-beat writes to the control word reach a core
  assign wr_ok = (offset == `CLUSTER_CTRL_OFFSET) && wlast;

  always_comb begin
    ctrl_wr = '0;
    if (accept && wr_ok) ctrl_wr[core_idx] = 1'b1;
  end

  assign ctrl_data = wdata;
  assign ctrl_strb = wstrb;

  always_ff @(posedge clk) begin
    if (rst) begin
      bvalid <= 1'b0;
    end else begin
      bvalid <= accept;   // bready is tied high, so one cycle only
    end
  end

  always_ff @(posedge clk) begin
    if (accept) bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
  end

endmodule

`default_nettype wire

// File: design/desc_collector.sv
`default_nettype none

`include "cluster_macros.svh"

module desc_collector (
  input  wire                                clk,
  input  wire                                rst,
  input  wire [`CLUSTER_NUM_CORES-1:0]       q_valid,
  input  wire cluster_desc_pkg::slot_idx_t   q_slot [`CLUSTER_NUM_CORES],
  input  wire cluster_desc_pkg::slot_addr_t  q_addr [`CLUSTER_NUM_CORES],
  output logic [`CLUSTER_NUM_CORES-1:0]      q_pop,
  output logic                               out_valid,
  output cluster_map_pkg::core_idx_t         out_core,
  output cluster_desc_pkg::slot_idx_t        out_slot,
  output cluster_desc_pkg::slot_addr_t       out_addr
);

  cluster_desc_pkg::rr_ptr_t  rr_ptr;
  logic                       found;
  cluster_map_pkg::core_idx_t grant;

  // first non-empty core at or after the pointer
  always_comb begin
    cluster_desc_pkg::rr_ptr_t idx;
    found = 1'b0;
    grant = '0;
    for (int i = 0; i < `CLUSTER_NUM_CORES; i++) begin
      idx = rr_ptr + cluster_desc_pkg::rr_ptr_t'(i);   // wraps with the pointer width
      if (!found && q_valid[idx]) begin
        found = 1'b1;
        grant = idx;
      end
    end
  end

  always_comb begin
    q_pop = '0;
    if (found) q_pop[grant] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rr_ptr    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= found;
      if (found) rr_ptr <= grant + 1'b1;  // skip past the winner
    end
  end

  always_ff @(posedge clk) begin
    if (found) begin
      out_core <= grant;
      out_slot <= q_slot[grant];
      out_addr <= q_addr[grant];
    end
  end

endmodule

`default_nettype wire

// File: dv/cluster_boot_tb.sv
`default_nettype none

`include "cluster_macros.svh"

module cluster_boot_tb;

  localparam int NUM_CORES       = `CLUSTER_NUM_CORES;
  localparam int NUM_SLOTS       = `CLUSTER_SLOTS;
  localparam int TOTAL_DESC      = NUM_CORES * NUM_SLOTS;
  localparam int RESTART_AT      = TOTAL_DESC / 2;   // mid-stream reset point
  localparam int RESET_CYCLES    = 16;
  localparam int WATCHDOG_CYCLES = 2 * `CLUSTER_BOOT_DELAY + 2000;

  logic                         clk;
  logic                         rst;
  logic                         tx_enable;
  logic                         rx_enable;
  logic [NUM_CORES-1:0]         cores_released;
  logic                         out_valid;
  cluster_map_pkg::core_idx_t   out_core;
  cluster_desc_pkg::slot_idx_t  out_slot;
  cluster_desc_pkg::slot_addr_t out_addr;

  // reference model state that every reset clears
  int                   cyc;
  int                   out_count;
  logic [NUM_CORES-1:0] prev_rel;
  logic                 prev_tx;
  logic                 seen [NUM_CORES][NUM_SLOTS];
  int                   last_slot [NUM_CORES];

  cluster_boot_top u_dut (
    .clk(clk), .rst(rst),
    .tx_enable(tx_enable), .rx_enable(rx_enable),
    .cores_released(cores_released),
    .out_valid(out_valid), .out_core(out_core), .out_slot(out_slot), .out_addr(out_addr)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ************************************************************************
  // error reporting and model helpers
  // ************************************************************************

  task automatic value_error(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    $display("FAIL %s: got %h expected %h", name, got, exp);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic rule_error(input string what);
    $display("%s", what);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  // slot n lives at base + n*step
  function automatic cluster_desc_pkg::slot_addr_t expected_slot_addr(input int slot);
    return 7'(`CLUSTER_SLOT_BASE + `CLUSTER_SLOT_STEP * slot);
  endfunction

  // cores come out of hold one per write from 0 upward
  function automatic logic [NUM_CORES-1:0] next_release(input logic [NUM_CORES-1:0] rel);
    return {rel[NUM_CORES-2:0], 1'b1};
  endfunction

  task automatic clear_model();
    cyc       = 0;
    out_count = 0;
    prev_rel  = '0;
    prev_tx   = 1'b0;
    foreach (seen[c, s]) seen[c][s] = 1'b0;
    foreach (last_slot[c]) last_slot[c] = -1;
  endtask

  task automatic check_output();
    assert (tx_enable) else rule_error("descriptor output before the enables were raised");
    assert (out_addr == expected_slot_addr(int'(out_slot)))
      else value_error("out_addr", out_addr, expected_slot_addr(int'(out_slot)));
    assert (!seen[out_core][out_slot])
      else rule_error($sformatf("duplicate descriptor for core %0d slot %0d",
                                out_core, out_slot));
    assert (int'(out_slot) > last_slot[out_core])
      else rule_error($sformatf("core %0d delivered slot %0d after slot %0d",
                                out_core, out_slot, last_slot[out_core]));
    seen[out_core][out_slot] = 1'b1;
    last_slot[out_core]      = int'(out_slot);
    out_count++;
  endtask

  // ************************************************************************
  // checker on the rising edge
  // ************************************************************************

  always @(posedge clk) begin
    if (rst) begin
      clear_model();
    end else begin
      cyc++;

      // nothing may come up during the boot delay
      if (cyc <= `CLUSTER_BOOT_DELAY) begin
        assert (cores_released == '0)
          else value_error("cores_released", cores_released, '0);
        assert (!tx_enable) else value_error("tx_enable", tx_enable, 1'b0);
        assert (!rx_enable) else value_error("rx_enable", rx_enable, 1'b0);
      end

      assert (cores_released == prev_rel || cores_released == next_release(prev_rel))
        else rule_error($sformatf("cores released out of order, %h after %h",
                                  cores_released, prev_rel));
      assert (tx_enable == rx_enable) else value_error("rx_enable", rx_enable, tx_enable);
      assert (!tx_enable || cores_released == '1)
        else rule_error("tx_enable raised before every core was released");
      assert (tx_enable || !prev_tx) else rule_error("tx_enable dropped without a reset");
      prev_rel = cores_released;
      prev_tx  = tx_enable;

      if (out_valid) check_output();
    end
  end

  // ************************************************************************
  // reset stimulus
  // ************************************************************************

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    // restart in the middle of the descriptor stream
    wait (out_count == RESTART_AT);
    @(negedge clk);
    rst = 1'b1;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    // all 128 pairs seen once, a stray extra one shows up as a duplicate
    wait (out_count == TOTAL_DESC);
    repeat (20) @(negedge clk);

    $display("No errors");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: descriptor stream did not complete within %0d cycles",
             WATCHDOG_CYCLES);
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/cluster_map_pkg.sv
design/cluster_desc_pkg.sv
design/boot_sequencer.sv
design/core_write_decoder.sv
design/core_slot_ctrl.sv
design/desc_collector.sv
design/cluster_boot_top.sv
dv/cluster_boot_tb.sv
